//--- sim.f
dcfeb_pkg.sv
adc_frame_deser.sv
sample_ring_buffer.sv
l1a_readout_ctrl.sv
daq_word_tx.sv
dcfeb_daq_top.sv
tb_dcfeb_daq.sv

//--- tb_dcfeb_daq.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcfeb_daq;
	import dcfeb_pkg::*;

	localparam int NUM_CH          = DEF_NUM_CH;
	localparam int NUM_SAMPLES     = DEF_NUM_SAMPLES;
	localparam int RING_DEPTH      = DEF_RING_DEPTH;
	localparam int L1A_QUEUE_DEPTH = DEF_L1A_QUEUE_DEPTH;
	localparam int MAX_FRAMES      = 1024;  // Frame log size, beyond the longest run
	localparam int NUM_EVENTS      = 8;     // 1 + 2 + 5 events over all tests
	// At most eight cycles per word with the slowest ack
	localparam int TIMEOUT_CYCLES  = NUM_EVENTS * NUM_CH * NUM_SAMPLES * 8 + 2000;

	logic               CMS_CLK_P;
	logic               reset;
	logic [NUM_CH-1:0]  ad_data;
	logic               frame;
	logic               l1a;
	pipe_depth_t        pipe_depth;
	logic               daq_ack;
	daq_word_t          daq_data;
	logic               daq_last;
	logic               daq_req;
	logic               l1a_lost;

	sample_t            sent_log [MAX_FRAMES][NUM_CH];  // Every frame sent, by frame number
	logic               last_bit;       // High with bit 11 on the lanes
	logic               valid_model;
	int                 frames_done;    // Frames written into the ring so far
	logic               ack_hold;
	int                 ack_delay_max;
	int                 exp_start [$];  // Start frame number of each L1A
	daq_word_t          rx_data [$];
	logic               rx_last [$];
	int                 last_cnt;
	int                 lost_cnt;
	logic               prev_req;
	daq_word_t          prev_data;
	logic               prev_last;
	int                 n_pass;
	int                 n_fail;
	int                 cycle_cnt;

	dcfeb_daq_top #(
		.NUM_CH          (NUM_CH),
		.NUM_SAMPLES     (NUM_SAMPLES),
		.RING_DEPTH      (RING_DEPTH),
		.L1A_QUEUE_DEPTH (L1A_QUEUE_DEPTH)
	) u_dcfeb_daq_top (
		.CMS_CLK_P  (CMS_CLK_P),
		.reset      (reset),
		.ad_data    (ad_data),
		.frame      (frame),
		.l1a        (l1a),
		.pipe_depth (pipe_depth),
		.daq_ack    (daq_ack),
		.daq_data   (daq_data),
		.daq_last   (daq_last),
		.daq_req    (daq_req),
		.l1a_lost   (l1a_lost)
	);

	initial begin
		CMS_CLK_P = 1'b0;
		forever #50 CMS_CLK_P = ~CMS_CLK_P;
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////
	function automatic logic [31:0] next_random(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) begin
			n_pass++;
		end else begin
			$display("Fail t=%0t %s got %0h expected %0h", $time, name, got, exp);
			n_fail++;
		end
	endtask

	// Called on a rising edge, returns on the edge that samples the L1A
	task automatic fire_l1a(input int depth);
		l1a        <= 1'b1;
		pipe_depth <= pipe_depth_t'(depth);
		@(posedge CMS_CLK_P);
		l1a <= 1'b0;
		exp_start.push_back(frames_done - depth);  // Count before this edge's write
	endtask

	task automatic wait_frames(input int n);
		while (frames_done < n) @(posedge CMS_CLK_P);
	endtask

	task automatic wait_last_words(input int base, input int n);
		while (last_cnt - base < n) @(posedge CMS_CLK_P);
	endtask

	// Words of each event against the frame log, channel 0 first
	task automatic check_events(input int n_events);
		int        e;
		int        f;
		int        ch;
		int        start;
		daq_word_t exp_word;
		check_eq("event word count", rx_data.size(), n_events * NUM_SAMPLES * NUM_CH);
		if (rx_data.size() != n_events * NUM_SAMPLES * NUM_CH) begin
			return;
		end
		for (e = 0; e < n_events; e++) begin
			start = exp_start.pop_front();
			for (f = 0; f < NUM_SAMPLES; f++) begin
				for (ch = 0; ch < NUM_CH; ch++) begin
					exp_word = {CH_IDX_BITS'(ch), sent_log[(start + f) % MAX_FRAMES][ch]};
					check_eq("daq_data", rx_data.pop_front(), exp_word);
					check_eq("daq_last", rx_last.pop_front(),
						(f == NUM_SAMPLES - 1) && (ch == NUM_CH - 1));
				end
			end
		end
	endtask

	task automatic report_test(input string name, input int fails_before);
		if (n_fail == fails_before) begin
			$display("Test %s: ok", name);
		end else begin
			$display("Test %s: %0d errors", name, n_fail - fails_before);
		end
	endtask

	////////////////////////////////////////////////////////////
	// ADC lanes, ack responder and monitors
	////////////////////////////////////////////////////////////
	initial begin
		logic [31:0]        seed;
		logic [NUM_CH-1:0]  lane_bits;
		int                 frames_sent;
		int                 ch;
		int                 b;
		seed        = 32'd61746;
		frames_sent = 0;
		repeat (4) @(posedge CMS_CLK_P);  // First bit goes out as reset drops
		forever begin
			for (ch = 0; ch < NUM_CH; ch++) begin
				seed = next_random(seed);
				sent_log[frames_sent % MAX_FRAMES][ch] = seed[27:16];
			end
			for (b = 0; b < SAMPLE_BITS; b++) begin
				for (ch = 0; ch < NUM_CH; ch++) begin
					lane_bits[ch] = sent_log[frames_sent % MAX_FRAMES][ch][b];  // LSB first
				end
				ad_data  <= lane_bits;
				frame    <= (b == 0);
				last_bit <= (b == SAMPLE_BITS - 1);
				@(posedge CMS_CLK_P);
			end
			frames_sent++;
		end
	end

	// Write count from bit 11, frame_valid a cycle later, then the write
	always @(posedge CMS_CLK_P) begin
		if (reset) begin
			valid_model <= 1'b0;
			frames_done <= 0;
		end else begin
			valid_model <= last_bit;
			if (valid_model) begin
				frames_done <= frames_done + 1;
			end
		end
	end

	initial begin
		logic [31:0] seed;
		int          delay;
		seed = 32'd61746;
		forever begin
			@(posedge CMS_CLK_P);
			if (daq_req && !ack_hold) begin
				seed  = next_random(seed);
				delay = seed[17:16] % (ack_delay_max + 1);
				repeat (delay) @(posedge CMS_CLK_P);
				daq_ack <= 1'b1;
				@(posedge CMS_CLK_P);
				while (daq_req) @(posedge CMS_CLK_P);
				daq_ack <= 1'b0;
			end
		end
	end

	// Mid-cycle sampling of the handshake
	always @(negedge CMS_CLK_P) begin
		if (!reset) begin
			if (daq_req && !prev_req) begin
				check_eq("daq_ack at daq_req rise", daq_ack, 1'b0);
				rx_data.push_back(daq_data);
				rx_last.push_back(daq_last);
				if (daq_last) begin
					last_cnt++;
				end
			end
			if (daq_req && prev_req) begin
				check_eq("daq_data", daq_data, prev_data);  // Held until ack
				check_eq("daq_last", daq_last, prev_last);
			end
			if (l1a_lost) begin
				lost_cnt++;
			end
		end
		prev_req  = daq_req;
		prev_data = daq_data;
		prev_last = daq_last;
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge CMS_CLK_P);
			cycle_cnt++;
		end
		$display("Timeout after %0d cycles, the events did not all arrive", cycle_cnt);
		$display("CHECKS FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////
	initial begin
		int fails_before;
		int last_base;
		int lost_base;
		int words_base;
		int i;
		reset         = 1'b1;
		ad_data       = '0;
		frame         = 1'b0;
		l1a           = 1'b0;
		pipe_depth    = pipe_depth_t'(1);
		daq_ack       = 1'b0;
		last_bit      = 1'b0;
		ack_hold      = 1'b0;
		ack_delay_max = 3;
		last_cnt      = 0;
		lost_cnt      = 0;
		prev_req      = 1'b0;
		n_pass        = 0;
		n_fail        = 0;
		repeat (4) @(posedge CMS_CLK_P);
		reset <= 1'b0;

		// Streaming with no L1A
		fails_before = n_fail;
		repeat (60) begin
			@(negedge CMS_CLK_P);
			check_eq("daq_req", daq_req, 1'b0);
			check_eq("l1a_lost", l1a_lost, 1'b0);
		end
		@(posedge CMS_CLK_P);
		report_test("idle stream", fails_before);

		// One L1A
		fails_before = n_fail;
		rx_data.delete();
		rx_last.delete();
		exp_start.delete();
		wait_frames(30);
		last_base = last_cnt;
		fire_l1a(20);
		wait_last_words(last_base, 1);
		check_events(1);
		report_test("single L1A", fails_before);

		// Second event has to leave before the ring laps it
		fails_before = n_fail;
		rx_data.delete();
		rx_last.delete();
		exp_start.delete();
		ack_delay_max <= 1;
		last_base = last_cnt;
		fire_l1a(40);
		repeat (4) @(posedge CMS_CLK_P);
		fire_l1a(10);
		wait_last_words(last_base, 2);
		check_events(2);
		ack_delay_max <= 3;
		report_test("two L1As", fails_before);

		// Queue overflow with ack held off
		fails_before = n_fail;
		ack_hold <= 1'b1;
		last_base = last_cnt;
		lost_base = lost_cnt;
		for (i = 0; i < L1A_QUEUE_DEPTH + 2; i++) begin
			fire_l1a(20);
			repeat (3) @(posedge CMS_CLK_P);
		end
		repeat (40) @(posedge CMS_CLK_P);
		check_eq("l1a_lost pulses", lost_cnt - lost_base, 1);
		ack_hold <= 1'b0;
		wait_last_words(last_base, L1A_QUEUE_DEPTH + 1);
		words_base = rx_data.size();
		repeat (100) @(posedge CMS_CLK_P);
		check_eq("words after drain", rx_data.size(), words_base);
		check_eq("daq_last words", last_cnt - last_base, L1A_QUEUE_DEPTH + 1);
		check_eq("l1a_lost pulses", lost_cnt - lost_base, 1);
		report_test("L1A overflow", fails_before);

		$display("Totals: %0d passing checks, %0d failing checks", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- dcfeb_daq_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcfeb_daq_top #(
	parameter int NUM_CH          = dcfeb_pkg::DEF_NUM_CH,
	parameter int NUM_SAMPLES     = dcfeb_pkg::DEF_NUM_SAMPLES,
	parameter int RING_DEPTH      = dcfeb_pkg::DEF_RING_DEPTH,
	parameter int L1A_QUEUE_DEPTH = dcfeb_pkg::DEF_L1A_QUEUE_DEPTH
) (
	input  wire                          CMS_CLK_P,
	input  wire                          reset,
	input  wire [NUM_CH-1:0]             ad_data,
	input  wire                          frame,
	input  wire                          l1a,
	input  wire dcfeb_pkg::pipe_depth_t  pipe_depth,
	input  wire                          daq_ack,
	output dcfeb_pkg::daq_word_t         daq_data,
	output logic                         daq_last,
	output logic                         daq_req,
	output logic                         l1a_lost
);
	import dcfeb_pkg::*;

	localparam int AW = $clog2(RING_DEPTH);

	sample_t [NUM_CH-1:0]  frame_data;
	logic                  frame_valid;
	logic [AW-1:0]         wr_ptr;
	logic                  rd_en;
	logic [AW-1:0]         rd_addr;
	sample_t [NUM_CH-1:0]  rd_data;
	sample_t [NUM_CH-1:0]  out_frame;
	logic                  out_valid;
	logic                  out_last_frame;
	logic                  frame_taken;

	////////////////////////////////////////////////////////////
	// ADC lanes into the ring
	////////////////////////////////////////////////////////////
	adc_frame_deser #(
		.NUM_CH (NUM_CH)
	) u_deser (
		.CMS_CLK_P   (CMS_CLK_P),
		.reset       (reset),
		.ad_data     (ad_data),
		.frame       (frame),
		.frame_data  (frame_data),
		.frame_valid (frame_valid)
	);

	sample_ring_buffer #(
		.NUM_CH     (NUM_CH),
		.RING_DEPTH (RING_DEPTH)
	) u_ring (
		.CMS_CLK_P   (CMS_CLK_P),
		.reset       (reset),
		.frame_data  (frame_data),
		.frame_valid (frame_valid),
		.rd_en       (rd_en),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.wr_ptr      (wr_ptr)
	);

	////////////////////////////////////////////////////////////
	// L1A readout and DAQ words
	////////////////////////////////////////////////////////////
	l1a_readout_ctrl #(
		.NUM_CH          (NUM_CH),
		.NUM_SAMPLES     (NUM_SAMPLES),
		.RING_DEPTH      (RING_DEPTH),
		.L1A_QUEUE_DEPTH (L1A_QUEUE_DEPTH)
	) u_readout (
		.CMS_CLK_P      (CMS_CLK_P),
		.reset          (reset),
		.l1a            (l1a),
		.pipe_depth     (pipe_depth),
		.wr_ptr         (wr_ptr),
		.rd_data        (rd_data),
		.frame_taken    (frame_taken),
		.rd_en          (rd_en),
		.rd_addr        (rd_addr),
		.out_frame      (out_frame),
		.out_valid      (out_valid),
		.out_last_frame (out_last_frame),
		.l1a_lost       (l1a_lost)
	);

	daq_word_tx #(
		.NUM_CH (NUM_CH)
	) u_tx (
		.CMS_CLK_P      (CMS_CLK_P),
		.reset          (reset),
		.out_frame      (out_frame),
		.out_valid      (out_valid),
		.out_last_frame (out_last_frame),
		.daq_ack        (daq_ack),
		.frame_taken    (frame_taken),
		.daq_data       (daq_data),
		.daq_last       (daq_last),
		.daq_req        (daq_req)
	);

endmodule

`default_nettype wire

//--- daq_word_tx.sv
`timescale 1ns/1ps
`default_nettype none

module daq_word_tx #(
	parameter int NUM_CH = dcfeb_pkg::DEF_NUM_CH
) (
	input  wire                                   CMS_CLK_P,
	input  wire                                   reset,
	input  wire dcfeb_pkg::sample_t [NUM_CH-1:0]  out_frame,
	input  wire                                   out_valid,
	input  wire                                   out_last_frame,
	input  wire                                   daq_ack,
	output logic                                  frame_taken,
	output dcfeb_pkg::daq_word_t                  daq_data,
	output logic                                  daq_last,
	output logic                                  daq_req
);
	import dcfeb_pkg::*;

	localparam int CW = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;

	// Four-phase handshake per word
	typedef enum logic [1:0] {T_IDLE, T_SETUP, T_REQ, T_RELEASE} tx_state_t;

	tx_state_t             state;
	sample_t [NUM_CH-1:0]  frame_reg;
	logic                  last_reg;   // Frame closes the event
	logic [CW-1:0]         ch_cnt;
	logic                  last_ch;

	assign last_ch     = (ch_cnt == CW'(NUM_CH-1));
	assign frame_taken = (state == T_IDLE) && out_valid;

	always_ff @(posedge CMS_CLK_P) begin
		if (reset) begin
			state    <= T_IDLE;
			ch_cnt   <= '0;
			last_reg <= 1'b0;
			daq_req  <= 1'b0;
			daq_last <= 1'b0;
		end else begin
			case (state)
				T_IDLE: begin
					if (frame_taken) begin
						last_reg <= out_last_frame;
						ch_cnt   <= '0;
						state    <= T_SETUP;
					end
				end
				T_SETUP: begin
					if (!daq_ack) begin  // Previous ack fully released
						daq_req  <= 1'b1;
						daq_last <= last_reg && last_ch;
						state    <= T_REQ;
					end
				end
				T_REQ: begin
					if (daq_ack) begin
						daq_req <= 1'b0;
						state   <= T_RELEASE;
					end
				end
				T_RELEASE: begin
					if (!daq_ack) begin
						daq_last <= 1'b0;
						if (last_ch) begin
							state <= T_IDLE;
						end else begin
							ch_cnt <= ch_cnt + 1'b1;
							state  <= T_SETUP;
						end
					end
				end
				default: state <= T_IDLE;
			endcase
		end
	end

	// Word loads together with the rising req
	always_ff @(posedge CMS_CLK_P) begin
		if (frame_taken) begin
			frame_reg <= out_frame;
		end
		if ((state == T_SETUP) && !daq_ack) begin
			daq_data <= {CH_IDX_BITS'(ch_cnt), frame_reg[ch_cnt]};
		end
	end

	a_req_rise: assert property (@(posedge CMS_CLK_P) disable iff (reset)
		$rose(daq_req) |-> !daq_ack)
		else $error("daq_req rose while daq_ack high");

endmodule

`default_nettype wire

//--- l1a_readout_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module l1a_readout_ctrl #(
	parameter  int NUM_CH          = dcfeb_pkg::DEF_NUM_CH,
	parameter  int NUM_SAMPLES     = dcfeb_pkg::DEF_NUM_SAMPLES,
	parameter  int RING_DEPTH      = dcfeb_pkg::DEF_RING_DEPTH,
	parameter  int L1A_QUEUE_DEPTH = dcfeb_pkg::DEF_L1A_QUEUE_DEPTH,
	localparam int AW              = $clog2(RING_DEPTH)
) (
	input  wire                                   CMS_CLK_P,
	input  wire                                   reset,
	input  wire                                   l1a,
	input  wire dcfeb_pkg::pipe_depth_t           pipe_depth,
	input  wire [AW-1:0]                          wr_ptr,
	input  wire dcfeb_pkg::sample_t [NUM_CH-1:0]  rd_data,
	input  wire                                   frame_taken,
	output logic                                  rd_en,
	output logic [AW-1:0]                         rd_addr,
	output dcfeb_pkg::sample_t [NUM_CH-1:0]      out_frame,
	output logic                                  out_valid,
	output logic                                  out_last_frame,
	output logic                                  l1a_lost
);
	localparam int QW   = (L1A_QUEUE_DEPTH > 1) ? $clog2(L1A_QUEUE_DEPTH) : 1;
	localparam int CNTW = $clog2(L1A_QUEUE_DEPTH + 1);
	localparam int SW   = (NUM_SAMPLES > 1) ? $clog2(NUM_SAMPLES) : 1;

	typedef enum logic [1:0] {S_IDLE, S_WAIT, S_OFFER} rd_state_t;

	rd_state_t        state;
	logic [AW-1:0]    l1a_queue [L1A_QUEUE_DEPTH];  // Start addresses
	logic [QW-1:0]    q_head;
	logic [QW-1:0]    q_tail;
	logic [CNTW-1:0]  q_count;
	logic             q_full;
	logic             q_push;
	logic             q_pop;
	logic [AW:0]      start_sum;
	logic [AW-1:0]    start_addr;
	logic [AW-1:0]    cur_addr;
	logic [SW-1:0]    frame_cnt;

	function automatic logic [QW-1:0] next_qptr(input logic [QW-1:0] p);
		if (p == QW'(L1A_QUEUE_DEPTH-1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	// wr_ptr - pipe_depth, modulo RING_DEPTH
	assign start_sum  = {1'b0, wr_ptr} + (AW+1)'(RING_DEPTH) - (AW+1)'(pipe_depth);
	assign start_addr = (start_sum >= (AW+1)'(RING_DEPTH)) ?
		AW'(start_sum - (AW+1)'(RING_DEPTH)) : AW'(start_sum);

	////////////////////////////////////////////////////////////
	// L1A queue
	////////////////////////////////////////////////////////////
	assign q_full = (q_count == CNTW'(L1A_QUEUE_DEPTH));
	assign q_push = l1a && !q_full;
	assign q_pop  = (state == S_IDLE) && (q_count != '0);  // Entry leaves as readout starts

	always_ff @(posedge CMS_CLK_P) begin
		if (reset) begin
			q_head   <= '0;
			q_tail   <= '0;
			q_count  <= '0;
			l1a_lost <= 1'b0;
		end else begin
			l1a_lost <= l1a && q_full;  // One cycle per dropped L1A
			if (q_push) begin
				q_tail <= next_qptr(q_tail);
			end
			if (q_pop) begin
				q_head <= next_qptr(q_head);
			end
			if (q_push && !q_pop) begin
				q_count <= q_count + 1'b1;
			end else if (q_pop && !q_push) begin
				q_count <= q_count - 1'b1;
			end
		end
	end

	always_ff @(posedge CMS_CLK_P) begin
		if (q_push) begin
			l1a_queue[q_tail] <= start_addr;
		end
	end

	////////////////////////////////////////////////////////////
	// Frame read sequencing
	////////////////////////////////////////////////////////////
	assign rd_en          = (state == S_WAIT) && (cur_addr != wr_ptr);  // Frame already written
	assign rd_addr        = cur_addr;
	assign out_valid      = (state == S_OFFER);
	assign out_frame      = rd_data;  // Read register holds still while offered
	assign out_last_frame = (frame_cnt == SW'(NUM_SAMPLES-1));

	always_ff @(posedge CMS_CLK_P) begin
		if (reset) begin
			state     <= S_IDLE;
			cur_addr  <= '0;
			frame_cnt <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (q_pop) begin
						cur_addr  <= l1a_queue[q_head];
						frame_cnt <= '0;
						state     <= S_WAIT;
					end
				end
				S_WAIT: begin
					if (rd_en) begin
						state <= S_OFFER;
					end
				end
				S_OFFER: begin
					if (frame_taken) begin
						if (out_last_frame) begin
							state <= S_IDLE;
						end else begin
							cur_addr  <= (cur_addr == AW'(RING_DEPTH-1)) ? '0 : cur_addr + 1'b1;
							frame_cnt <= frame_cnt + 1'b1;
							state     <= S_WAIT;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	a_pipe_depth_range: assert property (@(posedge CMS_CLK_P) disable iff (reset)
		l1a |-> (pipe_depth >= 1) && (pipe_depth <= RING_DEPTH - NUM_SAMPLES))
		else $error("pipe_depth %0d out of range at L1A", pipe_depth);

	a_offer_steady: assert property (@(posedge CMS_CLK_P) disable iff (reset)
		out_valid && !frame_taken |=> out_valid && $stable(out_frame))
		else $error("out_frame changed before frame_taken");

endmodule

`default_nettype wire

//--- sample_ring_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module sample_ring_buffer #(
	parameter  int NUM_CH     = dcfeb_pkg::DEF_NUM_CH,
	parameter  int RING_DEPTH = dcfeb_pkg::DEF_RING_DEPTH,
	localparam int AW         = $clog2(RING_DEPTH)
) (
	input  wire                                   CMS_CLK_P,
	input  wire                                   reset,
	input  wire dcfeb_pkg::sample_t [NUM_CH-1:0]  frame_data,
	input  wire                                   frame_valid,
	input  wire                                   rd_en,
	input  wire [AW-1:0]                          rd_addr,
	output dcfeb_pkg::sample_t [NUM_CH-1:0]      rd_data,
	output logic [AW-1:0]                         wr_ptr
);
	import dcfeb_pkg::*;

	sample_t [NUM_CH-1:0] ring_mem [RING_DEPTH];

	////////////////////////////////////////////////////////////
	// Write side
	////////////////////////////////////////////////////////////
	always_ff @(posedge CMS_CLK_P) begin
		if (reset) begin
			wr_ptr <= '0;
		end else if (frame_valid) begin
			if (wr_ptr == AW'(RING_DEPTH-1)) begin
				wr_ptr <= '0;  // Wrap, oldest frame is overwritten next
			end else begin
				wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge CMS_CLK_P) begin
		if (frame_valid) begin
			ring_mem[wr_ptr] <= frame_data;
		end
	end

	////////////////////////////////////////////////////////////
	// Registered read port
	////////////////////////////////////////////////////////////
	always_ff @(posedge CMS_CLK_P) begin
		if (rd_en) begin
			rd_data <= ring_mem[rd_addr];  // Valid the cycle after rd_en
		end
	end

endmodule

`default_nettype wire

//--- adc_frame_deser.sv
`timescale 1ns/1ps
`default_nettype none

module adc_frame_deser #(
	parameter int NUM_CH = dcfeb_pkg::DEF_NUM_CH
) (
	input  wire                               CMS_CLK_P,
	input  wire                               reset,
	input  wire [NUM_CH-1:0]                  ad_data,
	input  wire                               frame,
	output dcfeb_pkg::sample_t [NUM_CH-1:0]  frame_data,
	output logic                              frame_valid
);
	import dcfeb_pkg::*;

	localparam int CW = $clog2(SAMPLE_BITS);

	logic [CW-1:0]          bit_cnt;   // Index of the bit taken last
	logic [CW-1:0]          cur_bit;   // Index of the bit on the lanes now
	logic                   aligned;   // Seen at least one frame marker
	sample_t [NUM_CH-1:0]   shift_sr;

	// Frame marker forces bit 0, otherwise count on and wrap after bit 11
	assign cur_bit = frame ? '0 :
		(bit_cnt == CW'(SAMPLE_BITS-1)) ? '0 : bit_cnt + 1'b1;

	// Full frame sits in the shift registers for the cycle after bit 11
	assign frame_data = shift_sr;

	always_ff @(posedge CMS_CLK_P) begin
		if (reset) begin
			bit_cnt     <= '0;
			aligned     <= 1'b0;
			frame_valid <= 1'b0;
		end else begin
			bit_cnt     <= cur_bit;
			frame_valid <= aligned && (cur_bit == CW'(SAMPLE_BITS-1));
			if (frame) begin
				aligned <= 1'b1;
			end
		end
	end

	// LSB arrives first so shift in from the top
	always_ff @(posedge CMS_CLK_P) begin
		for (int ch = 0; ch < NUM_CH; ch++) begin
			shift_sr[ch] <= {ad_data[ch], shift_sr[ch][SAMPLE_BITS-1:1]};
		end
	end

	// Marker only after reset or right after a complete sample
	a_frame_aligned: assert property (@(posedge CMS_CLK_P) disable iff (reset)
		frame |-> (bit_cnt == '0) || (bit_cnt == CW'(SAMPLE_BITS-1)))
		else $error("frame marker at bit_cnt %0d", bit_cnt);

endmodule

`default_nettype wire

//--- dcfeb_pkg.sv
`default_nettype none

package dcfeb_pkg;

	////////////////////////////////////////////////////////////
	// Word and field widths
	////////////////////////////////////////////////////////////
	parameter int SAMPLE_BITS     = 12;  // One ADC conversion
	parameter int CH_IDX_BITS     = 4;   // Channel number in a DAQ word
	parameter int DAQ_WORD_BITS   = 16;
	parameter int PIPE_DEPTH_BITS = 7;

	typedef logic [SAMPLE_BITS-1:0]     sample_t;
	typedef logic [DAQ_WORD_BITS-1:0]   daq_word_t;
	typedef logic [PIPE_DEPTH_BITS-1:0] pipe_depth_t;  // L1A latency in frames

	////////////////////////////////////////////////////////////
	// Default sizes of the DAQ path
	////////////////////////////////////////////////////////////
	parameter int DEF_NUM_CH          = 16;
	parameter int DEF_NUM_SAMPLES     = 8;    // Frames per event
	parameter int DEF_RING_DEPTH      = 128;
	parameter int DEF_L1A_QUEUE_DEPTH = 4;

endpackage

`default_nettype wire
